// ==== include/conv_params.svh ====
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// frame length in samples
`define CONV_N 64

// filter length in taps
`define CONV_M 33

// width of samples, coefficients and outputs
`define CONV_T 16

// number of parallel lanes
// must divide the output count N - M + 1
`define CONV_P 4

`endif

// ==== verilog/conv_pkg.sv ====
`include "conv_params.svh"

package conv_pkg;

   // number of outputs per frame
   localparam int out_len = `CONV_N - `CONV_M + 1;

   typedef logic signed [`CONV_T-1:0] sample_t;
   typedef logic [$clog2(`CONV_N)-1:0] x_addr_t;
   typedef logic [$clog2(`CONV_M)-1:0] f_addr_t;
   // one extra bit so the count can reach N
   typedef logic [$clog2(`CONV_N):0] load_count_t;
   // runs to M + 1 to cover the read latency
   typedef logic [$clog2(`CONV_M)-1:0] tap_count_t;
   typedef logic [$clog2(out_len)-1:0] out_index_t;
   typedef logic [$clog2(`CONV_P)-1:0] lane_sel_t;

   typedef enum logic [1:0] {FRAME_INIT, FRAME_LOAD, FRAME_PROCESS} frame_state_t;
   typedef enum logic [2:0] {LANE_INIT, LANE_LOAD, LANE_CLEAR_ACC, LANE_FIRST_PIPE,
                             LANE_INC_INNER, LANE_WAIT_READY} lane_state_t;

endpackage

// ==== verilog/filter_rom.sv ====
`timescale 1ns/1ps

module filter_rom (
   input  logic               clk,
   input  conv_pkg::f_addr_t  addr,
   output conv_pkg::sample_t  coeff
);

   // fixed taps of the first layer, registered read
   always_ff @(posedge clk) begin
      case (addr)
         6'd0:  coeff <= -16'sd7;
         6'd1:  coeff <= 16'sd5;
         6'd2:  coeff <= 16'sd4;
         6'd3:  coeff <= -16'sd5;
         6'd4:  coeff <= -16'sd7;
         6'd5:  coeff <= 16'sd4;
         6'd6:  coeff <= -16'sd8;
         6'd7:  coeff <= -16'sd7;
         6'd8:  coeff <= 16'sd6;
         6'd9:  coeff <= 16'sd1;
         6'd10: coeff <= -16'sd7;
         6'd11: coeff <= -16'sd4;
         6'd12: coeff <= -16'sd1;
         6'd13: coeff <= -16'sd7;
         6'd14: coeff <= 16'sd0;
         6'd15: coeff <= 16'sd0;
         6'd16: coeff <= -16'sd6;
         6'd17: coeff <= -16'sd1;
         6'd18: coeff <= -16'sd8;
         6'd19: coeff <= 16'sd0;
         6'd20: coeff <= -16'sd8;
         6'd21: coeff <= 16'sd7;
         6'd22: coeff <= -16'sd5;
         6'd23: coeff <= -16'sd4;
         6'd24: coeff <= 16'sd0;
         6'd25: coeff <= 16'sd4;
         6'd26: coeff <= -16'sd5;
         6'd27: coeff <= 16'sd0;
         6'd28: coeff <= -16'sd3;
         6'd29: coeff <= -16'sd1;
         6'd30: coeff <= -16'sd8;
         6'd31: coeff <= -16'sd2;
         6'd32: coeff <= -16'sd4;
         // taps past the end contribute nothing
         default: coeff <= 16'sd0;
      endcase
   end

endmodule

// ==== verilog/lane_datapath.sv ====
`timescale 1ns/1ps
`include "conv_params.svh"

module lane_datapath (
   input  logic                   clk,
   input  logic                   reset,
   input  conv_pkg::sample_t      x_data,
   input  logic                   wr_en,
   input  conv_pkg::load_count_t  load_count,
   input  conv_pkg::x_addr_t      x_addr,
   input  conv_pkg::f_addr_t      f_addr,
   input  logic                   clear_acc,
   input  logic                   en_acc,
   output conv_pkg::sample_t      y_data
);

   localparam int sat_max = 2**(`CONV_T-1) - 1;
   localparam int sat_min = -(2**(`CONV_T-1));

   conv_pkg::sample_t x_mem [`CONV_N];
   conv_pkg::x_addr_t mem_addr;
   conv_pkg::sample_t x_q;
   conv_pkg::sample_t f_q;
   conv_pkg::sample_t prod_q;
   conv_pkg::sample_t acc;
   logic signed [2*`CONV_T-1:0] product;
   logic signed [`CONV_T:0] sum;

   // load writes at the input count, compute reads at the lane's address
   assign mem_addr = wr_en ? load_count[$clog2(`CONV_N)-1:0] : x_addr;

   // sample copy of this lane, one cycle read latency
   always_ff @(posedge clk) begin
      x_q <= x_mem[mem_addr];
      if (wr_en) begin
         x_mem[mem_addr] <= x_data;
      end
   end

   filter_rom u_filter_rom (
      .clk   (clk),
      .addr  (f_addr),
      .coeff (f_q)
   );

   // full width product, clamped into the pipeline register
   assign product = x_q * f_q;

   always_ff @(posedge clk) begin
      if (product > sat_max) begin
         prod_q <= conv_pkg::sample_t'(sat_max);
      end else if (product < sat_min) begin
         prod_q <= conv_pkg::sample_t'(sat_min);
      end else begin
         prod_q <= product[`CONV_T-1:0];
      end
   end

   // one guard bit catches overflow of the running sum
   assign sum = acc + prod_q;

   always_ff @(posedge clk) begin
      if (reset || clear_acc) begin
         acc <= '0;
      end else if (en_acc) begin
         if (sum > sat_max) begin
            acc <= conv_pkg::sample_t'(sat_max);
         end else if (sum < sat_min) begin
            acc <= conv_pkg::sample_t'(sat_min);
         end else begin
            acc <= sum[`CONV_T-1:0];
         end
      end
   end

   // relu on the finished sum
   assign y_data = acc[`CONV_T-1] ? '0 : acc;

endmodule

// ==== verilog/lane_ctrl.sv ====
`timescale 1ns/1ps
`include "conv_params.svh"

module lane_ctrl #(
   parameter int lane_index = 0
) (
   input  logic               clk,
   input  logic               reset,
   input  logic               load_done,
   input  logic               lane_ready,
   output conv_pkg::x_addr_t  x_addr,
   output conv_pkg::f_addr_t  f_addr,
   output logic               clear_acc,
   output logic               en_acc,
   output logic               lane_valid,
   output logic               lane_done
);

   conv_pkg::lane_state_t state;
   conv_pkg::lane_state_t next_state;
   conv_pkg::tap_count_t tap_cnt;
   conv_pkg::out_index_t out_idx;
   logic computing;
   logic done_inner;
   logic done_outer;
   logic inc_inner;

   // inner loop stops at M + 1, two cycles of read and product latency
   assign done_inner = (tap_cnt == `CONV_M + 1);
   // last output owned by this lane
   assign done_outer = (out_idx >= conv_pkg::out_len - `CONV_P);

   always_comb begin
      case (state)
         conv_pkg::LANE_INIT:       next_state = conv_pkg::LANE_LOAD;
         conv_pkg::LANE_LOAD:       next_state = load_done ? conv_pkg::LANE_CLEAR_ACC
                                                           : conv_pkg::LANE_LOAD;
         conv_pkg::LANE_CLEAR_ACC:  next_state = conv_pkg::LANE_FIRST_PIPE;
         conv_pkg::LANE_FIRST_PIPE: next_state = conv_pkg::LANE_INC_INNER;
         conv_pkg::LANE_INC_INNER:  next_state = done_inner ? conv_pkg::LANE_WAIT_READY
                                                            : conv_pkg::LANE_INC_INNER;
         conv_pkg::LANE_WAIT_READY: begin
            // hold until the arbiter hands us the port
            if (!lane_ready) begin
               next_state = conv_pkg::LANE_WAIT_READY;
            end else if (done_outer) begin
               next_state = conv_pkg::LANE_LOAD;
            end else begin
               next_state = conv_pkg::LANE_CLEAR_ACC;
            end
         end
         default:                   next_state = conv_pkg::LANE_INIT;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= conv_pkg::LANE_INIT;
      end else begin
         state <= next_state;
      end
   end

   assign computing = (state == conv_pkg::LANE_CLEAR_ACC) ||
                      (state == conv_pkg::LANE_FIRST_PIPE) ||
                      (state == conv_pkg::LANE_INC_INNER);
   assign inc_inner = computing && !done_inner;

   // inner counter is zero when CLEAR_ACC starts
   always_ff @(posedge clk) begin
      if (reset || next_state == conv_pkg::LANE_CLEAR_ACC) begin
         tap_cnt <= '0;
      end else if (inc_inner) begin
         tap_cnt <= tap_cnt + 1'b1;
      end
   end

   // outer index strides by the lane count from this lane's first output
   always_ff @(posedge clk) begin
      if (reset || lane_done) begin
         out_idx <= conv_pkg::out_index_t'(lane_index);
      end else if (lane_valid && lane_ready) begin
         out_idx <= out_idx + conv_pkg::out_index_t'(`CONV_P);
      end
   end

   // x[n+k] and f[k]; reads past the frame end are never accumulated
   assign x_addr = computing ? tap_cnt + conv_pkg::x_addr_t'(out_idx) : '0;
   assign f_addr = computing ? tap_cnt : '0;

   assign clear_acc  = (state == conv_pkg::LANE_CLEAR_ACC);
   assign en_acc     = (state == conv_pkg::LANE_INC_INNER);
   assign lane_valid = (state == conv_pkg::LANE_WAIT_READY);
   assign lane_done  = lane_valid && lane_ready && done_outer;

endmodule

// ==== verilog/load_ctrl.sv ====
`timescale 1ns/1ps
`include "conv_params.svh"

module load_ctrl (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   x_valid,
   input  logic                   frame_done,
   output logic                   x_ready,
   output logic                   wr_en,
   output conv_pkg::load_count_t  load_count,
   output logic                   load_done
);

   conv_pkg::frame_state_t state;
   conv_pkg::frame_state_t next_state;

   always_comb begin
      case (state)
         conv_pkg::FRAME_INIT:    next_state = conv_pkg::FRAME_LOAD;
         conv_pkg::FRAME_LOAD:    next_state = load_done ? conv_pkg::FRAME_PROCESS
                                                         : conv_pkg::FRAME_LOAD;
         // lanes own the frame until the last output has left
         conv_pkg::FRAME_PROCESS: next_state = frame_done ? conv_pkg::FRAME_LOAD
                                                          : conv_pkg::FRAME_PROCESS;
         default:                 next_state = conv_pkg::FRAME_INIT;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= conv_pkg::FRAME_INIT;
      end else begin
         state <= next_state;
      end
   end

   // one count per accepted sample, parked at N while processing
   always_ff @(posedge clk) begin
      if (reset || frame_done) begin
         load_count <= '0;
      end else if (x_valid && x_ready) begin
         load_count <= load_count + 1'b1;
      end
   end

   assign x_ready   = (state == conv_pkg::FRAME_LOAD) && (load_count < `CONV_N);
   // a write without valid is overwritten by the next accepted sample
   assign wr_en     = x_ready;
   assign load_done = x_ready && x_valid && (load_count == `CONV_N - 1);

endmodule

// ==== verilog/output_arbiter.sv ====
`timescale 1ns/1ps
`include "conv_params.svh"

module output_arbiter (
   input  logic               clk,
   input  logic               reset,
   input  logic [`CONV_P-1:0] lane_valid,
   input  logic [`CONV_P-1:0] lane_done,
   input  conv_pkg::sample_t  lane_data [`CONV_P],
   input  logic               y_ready,
   output logic [`CONV_P-1:0] lane_ready,
   output logic               y_valid,
   output conv_pkg::sample_t  y_data,
   output logic               frame_done
);

   // lane that owns the output port now
   conv_pkg::lane_sel_t ptr;
   logic last_lane;

   assign last_lane = (ptr == conv_pkg::lane_sel_t'(`CONV_P - 1));

   // only the granted lane sees the downstream ready
   always_comb begin
      lane_ready      = '0;
      lane_ready[ptr] = y_ready;
   end

   assign y_valid = lane_valid[ptr];
   assign y_data  = lane_data[ptr];

   // outputs leave in index order, so step one lane per transfer
   always_ff @(posedge clk) begin
      if (reset) begin
         ptr <= '0;
      end else if (y_valid && y_ready) begin
         if (last_lane) begin
            ptr <= '0;
         end else begin
            ptr <= ptr + 1'b1;
         end
      end
   end

   // last lane's final transfer closes the frame
   assign frame_done = lane_done[ptr] && last_lane;

endmodule

// ==== verilog/conv_layer.sv ====
`timescale 1ns/1ps
`include "conv_params.svh"

module conv_layer (
   input  logic               clk,
   input  logic               reset,
   input  conv_pkg::sample_t  x_data,
   input  logic               x_valid,
   output logic               x_ready,
   output conv_pkg::sample_t  y_data,
   output logic               y_valid,
   input  logic               y_ready
);

   logic wr_en;
   conv_pkg::load_count_t load_count;
   logic load_done;
   logic frame_done;
   logic [`CONV_P-1:0] lane_valid;
   logic [`CONV_P-1:0] lane_done;
   logic [`CONV_P-1:0] lane_ready;
   conv_pkg::sample_t lane_data [`CONV_P];

   // shared input side, every lane stores the same frame
   load_ctrl u_load_ctrl (
      .clk        (clk),
      .reset      (reset),
      .x_valid    (x_valid),
      .frame_done (frame_done),
      .x_ready    (x_ready),
      .wr_en      (wr_en),
      .load_count (load_count),
      .load_done  (load_done)
   );

   // lane i computes outputs i, i+P, i+2P and so on
   for (genvar i = 0; i < `CONV_P; i++) begin : g_lane
      conv_pkg::x_addr_t x_addr;
      conv_pkg::f_addr_t f_addr;
      logic clear_acc;
      logic en_acc;

      lane_ctrl #(
         .lane_index (i)
      ) u_lane_ctrl (
         .clk        (clk),
         .reset      (reset),
         .load_done  (load_done),
         .lane_ready (lane_ready[i]),
         .x_addr     (x_addr),
         .f_addr     (f_addr),
         .clear_acc  (clear_acc),
         .en_acc     (en_acc),
         .lane_valid (lane_valid[i]),
         .lane_done  (lane_done[i])
      );

      lane_datapath u_lane_datapath (
         .clk        (clk),
         .reset      (reset),
         .x_data     (x_data),
         .wr_en      (wr_en),
         .load_count (load_count),
         .x_addr     (x_addr),
         .f_addr     (f_addr),
         .clear_acc  (clear_acc),
         .en_acc     (en_acc),
         .y_data     (lane_data[i])
      );
   end

   // lanes share the single output port in turn
   output_arbiter u_output_arbiter (
      .clk        (clk),
      .reset      (reset),
      .lane_valid (lane_valid),
      .lane_done  (lane_done),
      .lane_data  (lane_data),
      .y_ready    (y_ready),
      .lane_ready (lane_ready),
      .y_valid    (y_valid),
      .y_data     (y_data),
      .frame_done (frame_done)
   );

endmodule

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
   parameter int half_period = 2
) (
   output logic clk
);

   // 4 ns period, first rising edge at 2 ns
   initial begin
      clk = 1'b0;
      forever begin
         #(half_period) clk = ~clk;
      end
   end

endmodule

// ==== dv/conv_layer_tb.sv ====
`timescale 1ns/1ps
`include "conv_params.svh"

module conv_layer_tb;

   localparam int out_len = `CONV_N - `CONV_M + 1;
   localparam int wait_limit = 4000;
   localparam int sat_max = 32767;
   localparam int sat_min = -32768;
   // first layer taps, tap 0 first
   localparam int coeffs [`CONV_M] = '{-7, 5, 4, -5, -7, 4, -8, -7, 6, 1, -7, -4, -1,
                                       -7, 0, 0, -6, -1, -8, 0, -8, 7, -5, -4, 0, 4,
                                       -5, 0, -3, -1, -8, -2, -4};

   logic clk;
   logic reset;
   conv_pkg::sample_t x_data;
   logic x_valid;
   logic x_ready;
   conv_pkg::sample_t y_data;
   logic y_valid;
   logic y_ready;

   int seed;
   // y_ready pattern for the back-pressure frames, drawn once at start
   logic ready_pattern [1024];
   int ready_idx;
   logic bp_mode;
   conv_pkg::sample_t frame_buf [`CONV_N];
   conv_pkg::sample_t exp_q [$];
   conv_pkg::sample_t exp_head;
   int exp_size;
   // per-frame transfer counts, busy from the 64th sample to the 32nd output
   int in_count;
   int out_count;
   logic busy;
   int value_errors;
   int protocol_errors;
   int timeouts;

   tb_clock u_clock (
      .clk (clk)
   );

   conv_layer DUT (
      .clk     (clk),
      .reset   (reset),
      .x_data  (x_data),
      .x_valid (x_valid),
      .x_ready (x_ready),
      .y_data  (y_data),
      .y_valid (y_valid),
      .y_ready (y_ready)
   );

   // clamp to the 16-bit signed range
   function automatic int sat16(input int v);
      if (v > sat_max) begin
         return sat_max;
      end else if (v < sat_min) begin
         return sat_min;
      end
      return v;
   endfunction

   // kind 0 small random, kind 1 near full scale, kind 2 all zero
   function automatic void fill_frame(input int kind);
      int v;
      for (int i = 0; i < `CONV_N; i++) begin
         if (kind == 0) begin
            v = $random(seed) % 256;
         end else if (kind == 1) begin
            v = ($random(seed) & 1) ? sat_max - ($random(seed) & 15)
                                    : sat_min + ($random(seed) & 15);
         end else begin
            v = 0;
         end
         frame_buf[i] = conv_pkg::sample_t'(v);
      end
   endfunction

   // saturated products, saturated sum in tap order, then relu
   function automatic void push_expected();
      int acc;
      int prod;
      for (int n = 0; n < out_len; n++) begin
         acc = 0;
         for (int k = 0; k < `CONV_M; k++) begin
            prod = sat16(int'(frame_buf[n + k]) * coeffs[k]);
            acc = sat16(acc + prod);
         end
         if (acc < 0) begin
            acc = 0;
         end
         exp_q.push_back(conv_pkg::sample_t'(acc));
      end
   endfunction

   // called on a falling edge, returns on a falling edge
   task automatic wait_x_ready(input int limit);
      int waited;
      begin
         waited = 0;
         while (!x_ready && waited < limit) begin
            @(negedge clk);
            waited++;
         end
         if (!x_ready) begin
            timeouts++;
            $display("timeout at %0t: x_ready stayed low for %0d cycles", $time, limit);
         end
      end
   endtask

   task automatic send_frame(input int kind, input bit gaps);
      begin
         fill_frame(kind);
         push_expected();
         for (int i = 0; i < `CONV_N; i++) begin
            if (timeouts == 0) begin
               // random idle cycle on the input side
               if (gaps && ($random(seed) & 3) == 0) begin
                  x_valid = 1'b0;
                  @(negedge clk);
               end
               x_data = frame_buf[i];
               x_valid = 1'b1;
               wait_x_ready(wait_limit);
               // transfer on the rising edge in between
               if (timeouts == 0) begin
                  @(negedge clk);
               end
            end
         end
         x_valid = 1'b0;
      end
   endtask

   task automatic wait_drained(input int limit);
      int waited;
      begin
         waited = 0;
         while (exp_q.size() > 0 && waited < limit) begin
            @(negedge clk);
            waited++;
         end
         if (exp_q.size() > 0) begin
            timeouts++;
            $display("timeout at %0t: %0d expected outputs never arrived", $time,
                     exp_q.size());
         end
      end
   endtask

   // y_ready on the falling edge, pattern only in back-pressure mode
   always @(negedge clk) begin
      if (reset) begin
         y_ready <= 1'b0;
      end else if (bp_mode) begin
         y_ready <= ready_pattern[ready_idx];
         ready_idx <= (ready_idx + 1) % 1024;
      end else begin
         y_ready <= 1'b1;
      end
   end

   // transfer bookkeeping
   always @(posedge clk) begin
      if (reset) begin
         in_count <= 0;
         out_count <= 0;
         busy <= 1'b0;
      end else begin
         if (x_valid && x_ready) begin
            if (in_count == `CONV_N - 1) begin
               in_count <= 0;
               busy <= 1'b1;
            end else begin
               in_count <= in_count + 1;
            end
         end
         if (y_valid && y_ready) begin
            if (exp_q.size() > 0) begin
               void'(exp_q.pop_front());
            end
            if (out_count == out_len - 1) begin
               out_count <= 0;
               busy <= 1'b0;
            end else begin
               out_count <= out_count + 1;
            end
         end
      end
   end

   // head of the queue, stable across the next rising edge
   always @(negedge clk) begin
      exp_size = exp_q.size();
      exp_head = (exp_size > 0) ? exp_q[0] : '0;
   end

   a_reset_quiet: assert property (@(negedge clk) reset |-> (!x_ready && !y_valid))
      else begin
         protocol_errors++;
         $display("x_ready or y_valid is high during reset at %0t", $time);
      end

   a_y_expected: assert property (@(posedge clk) disable iff (reset)
      (y_valid && y_ready) |-> (exp_size > 0))
      else begin
         protocol_errors++;
         $display("output transfer at %0t with no expected value left", $time);
      end

   a_y_value: assert property (@(posedge clk) disable iff (reset)
      (y_valid && y_ready && exp_size > 0) |-> (y_data == exp_head))
      else begin
         value_errors++;
         $display("error at %0t: y_data is %0d, expected %0d", $time, $sampled(y_data),
                  $sampled(exp_head));
      end

   // relu, never a negative output
   a_y_relu: assert property (@(posedge clk) disable iff (reset)
      y_valid |-> !y_data[`CONV_T-1])
      else begin
         value_errors++;
         $display("error at %0t: y_data is %0d, expected a value of 0 or more", $time,
                  $sampled(y_data));
      end

   a_y_hold: assert property (@(posedge clk) disable iff (reset)
      (y_valid && !y_ready) |=> (y_valid && $stable(y_data)))
      else begin
         protocol_errors++;
         $display("y_valid dropped or y_data changed while y_ready was low at %0t", $time);
      end

   a_x_busy: assert property (@(posedge clk) disable iff (reset) busy |-> !x_ready)
      else begin
         protocol_errors++;
         $display("x_ready high at %0t before all outputs of the frame were sent", $time);
      end

   a_x_drop: assert property (@(posedge clk) disable iff (reset) $fell(x_ready) |-> busy)
      else begin
         protocol_errors++;
         $display("x_ready fell at %0t before 64 samples were taken", $time);
      end

   initial begin
      seed = 32'he0bf_37b5;
      reset = 1'b1;
      x_data = '0;
      x_valid = 1'b0;
      y_ready = 1'b0;
      bp_mode = 1'b0;
      ready_idx = 0;
      value_errors = 0;
      protocol_errors = 0;
      timeouts = 0;
      // ready about three cycles in four
      for (int i = 0; i < 1024; i++) begin
         ready_pattern[i] = ($random(seed) & 3) != 0;
      end
      repeat (4) @(negedge clk);
      reset = 1'b0;
      wait_x_ready(4);
      // frames follow each other, each one waits for x_ready
      send_frame(0, 1'b1);
      send_frame(1, 1'b0);
      send_frame(2, 1'b1);
      bp_mode = 1'b1;
      send_frame(0, 1'b1);
      send_frame(1, 1'b1);
      if (timeouts == 0) begin
         wait_drained(wait_limit);
      end
      // input side reopens after the last output
      if (timeouts == 0) begin
         wait_x_ready(8);
      end
      $display("checks done: %0d value errors, %0d protocol errors, %0d timeouts",
               value_errors, protocol_errors, timeouts);
      if (value_errors == 0 && protocol_errors == 0 && timeouts == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== list.f ====
+incdir+include
verilog/conv_pkg.sv
verilog/filter_rom.sv
verilog/lane_datapath.sv
verilog/lane_ctrl.sv
verilog/load_ctrl.sv
verilog/output_arbiter.sv
verilog/conv_layer.sv
dv/tb_clock.sv
dv/conv_layer_tb.sv

// ==== Bender.yml ====
package:
  name: conv_layer

sources:
  - include_dirs:
      - include
    files:
      - verilog/conv_pkg.sv
      - verilog/filter_rom.sv
      - verilog/lane_datapath.sv
      - verilog/lane_ctrl.sv
      - verilog/load_ctrl.sv
      - verilog/output_arbiter.sv
      - verilog/conv_layer.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/tb_clock.sv
      - dv/conv_layer_tb.sv
